//--- logic/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;
  localparam int reg_addr_bits = 5;
  localparam int strb_bits = 4;
  localparam logic [xlen-1:0] reset_pc = '0;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_bits-1:0] reg_idx_t;

  // major opcodes, low two bits always 2'b11
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    st_fetch,
    st_wait_instr,
    st_execute,
    st_mem_wait,
    st_writeback,
    st_trap
  } cpu_state_e;

  typedef struct packed {
    opcode_e  opcode;
    alu_op_e  alu_op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    // branch condition, or load/store size and sign
    logic [2:0] funct3;
    logic     imm_sel;
    logic     illegal;
  } decoded_t;

  // all strobes zero means a read
  typedef struct packed {
    word_t                addr;
    word_t                wdata;
    logic [strb_bits-1:0] strb;
    logic                 instr;
  } mem_req_t;

endpackage

//--- logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
  import rv_pkg::*;
(
  input  word_t    instr,
  output decoded_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // funct3 to ALU operation, alt picks sub or sra
  function automatic alu_op_e alu_func(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec.opcode = opcode_e'(opcode);
    dec.alu_op = alu_add;
    dec.rd = instr[11:7];
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.imm = imm_i;
    dec.funct3 = funct3;
    dec.imm_sel = 1'b0;
    dec.illegal = 1'b0;
    case (opcode)
      opc_lui, opc_auipc: dec.imm = imm_u;
      opc_jal: dec.imm = imm_j;
      opc_jalr: dec.illegal = funct3 != 3'b000;
      opc_branch: begin
        dec.imm = imm_b;
        dec.illegal = funct3[2:1] == 2'b01;
      end
      opc_load: dec.illegal = funct3 == 3'b011 || funct3[2:1] == 2'b11;
      opc_store: begin
        dec.imm = imm_s;
        dec.illegal = funct3[2] || funct3 == 3'b011;
      end
      opc_op_imm: begin
        dec.imm_sel = 1'b1;
        dec.alu_op = alu_func(funct3, funct3 == 3'b101 && funct7[5]);
        // shift immediates carry funct7 in the upper bits
        if (funct3 == 3'b001) begin
          dec.illegal = funct7 != 7'b0000000;
        end else if (funct3 == 3'b101) begin
          dec.illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
        end
      end
      opc_op: begin
        dec.alu_op = alu_func(funct3, funct7[5]);
        dec.illegal = funct7 != 7'b0000000 &&
                      !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      default: dec.illegal = 1'b1;
    endcase
  end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu
  import rv_pkg::*;
(
  input  word_t      op_a,
  input  word_t      op_b,
  input  alu_op_e    alu_op,
  input  logic [2:0] funct3,
  output word_t      result,
  output logic       branch_taken
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = op_b[4:0];
  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  always_comb begin
    case (alu_op)
      alu_add:  result = op_a + op_b;
      alu_sub:  result = op_a - op_b;
      alu_sll:  result = op_a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:  result = op_a ^ op_b;
      alu_srl:  result = op_a >> shamt;
      alu_sra:  result = $signed(op_a) >>> shamt;
      alu_or:   result = op_a | op_b;
      alu_and:  result = op_a & op_b;
      default:  result = '0;
    endcase
  end

  // beq bne, then blt bge bltu bgeu
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = op_a == op_b;
      3'b001:  branch_taken = op_a != op_b;
      3'b100:  branch_taken = lt_s;
      3'b101:  branch_taken = !lt_s;
      3'b110:  branch_taken = lt_u;
      3'b111:  branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

//--- logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit
  import rv_pkg::*;
(
  input  decoded_t dec,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    mem_rdata,
  output mem_req_t data_req,
  output logic     misaligned,
  output word_t    load_data
);

  word_t      addr;
  logic [1:0] offset;
  word_t      lane;

  assign addr = rs1_data + dec.imm;
  assign offset = addr[1:0];

  always_comb begin
    data_req.addr = {addr[xlen-1:2], 2'b00};
    data_req.wdata = rs2_data;
    data_req.strb = '0;
    data_req.instr = 1'b0;
    if (dec.opcode == opc_store) begin
      case (dec.funct3[1:0])
        2'b00: begin
          data_req.wdata = {4{rs2_data[7:0]}};
          data_req.strb = 4'b0001 << offset;
        end
        2'b01: begin
          data_req.wdata = {2{rs2_data[15:0]}};
          data_req.strb = offset[1] ? 4'b1100 : 4'b0011;
        end
        default: data_req.strb = {strb_bits{1'b1}};
      endcase
    end
  end

  always_comb begin
    case (dec.funct3[1:0])
      2'b00:   misaligned = 1'b0;
      2'b01:   misaligned = offset[0];
      default: misaligned = |offset;
    endcase
  end

  // bring the addressed byte or halfword down to bit 0
  assign lane = mem_rdata >> {offset, 3'b000};

  always_comb begin
    case (dec.funct3)
      3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};
      3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};
      3'b100:  load_data = {24'b0, lane[7:0]};
      3'b101:  load_data = {16'b0, lane[15:0]};
      default: load_data = lane;
    endcase
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file
  import rv_pkg::*;
(
  input  logic     clk,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    rd_data
);

  word_t regs [reg_count];

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- logic/core_sequencer.sv
`timescale 1ns/1ps

module core_sequencer
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     mem_ready,
  input  word_t    mem_rdata,
  output logic     mem_valid,
  output mem_req_t mem_req,
  output logic     trap,
  output word_t    instr,
  input  decoded_t dec,
  input  word_t    alu_result,
  input  logic     branch_taken,
  input  mem_req_t data_req,
  input  logic     misaligned,
  input  word_t    load_data,
  output logic     rf_we,
  output reg_idx_t rf_rd,
  output word_t    rf_wdata,
  input  word_t    rs1_data
);

  cpu_state_e state;
  word_t      pc;
  word_t      next_pc;
  word_t      wb_data;
  word_t      pc_plus4;
  word_t      pc_rel;
  word_t      jalr_sum;
  word_t      target;
  word_t      exec_result;
  logic       fault;

  assign pc_plus4 = pc + 32'd4;
  assign pc_rel = pc + dec.imm;
  assign jalr_sum = rs1_data + dec.imm;
  assign target = (dec.opcode == opc_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc_rel;

  always_comb begin
    case (dec.opcode)
      opc_lui:   exec_result = dec.imm;
      opc_auipc: exec_result = pc_rel;
      default:   exec_result = alu_result;
    endcase
  end

  always_comb begin
    case (dec.opcode)
      opc_jal, opc_jalr:   fault = |target[1:0];
      opc_branch:          fault = branch_taken && |target[1:0];
      opc_load, opc_store: fault = misaligned;
      default:             fault = 1'b0;
    endcase
    if (dec.illegal) begin
      fault = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      mem_valid <= 1'b0;
      trap <= 1'b0;
      next_pc <= reset_pc;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_req <= '{addr: next_pc, wdata: '0, strb: '0, instr: 1'b1};
          state <= st_wait_instr;
        end
        st_wait_instr: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            instr <= mem_rdata;
            pc <= mem_req.addr;
            state <= st_execute;
          end
        end
        st_execute: begin
          if (fault) begin
            trap <= 1'b1;
            state <= st_trap;
          end else begin
            case (dec.opcode)
              opc_branch: begin
                next_pc <= branch_taken ? target : pc_plus4;
                state <= st_fetch;
              end
              opc_load, opc_store: begin
                mem_valid <= 1'b1;
                mem_req <= data_req;
                next_pc <= pc_plus4;
                state <= st_mem_wait;
              end
              opc_jal, opc_jalr: begin
                // link value
                wb_data <= pc_plus4;
                next_pc <= target;
                state <= st_writeback;
              end
              default: begin
                wb_data <= exec_result;
                next_pc <= pc_plus4;
                state <= st_writeback;
              end
            endcase
          end
        end
        st_mem_wait: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            wb_data <= load_data;
            state <= (mem_req.strb == '0) ? st_writeback : st_fetch;
          end
        end
        st_writeback: state <= st_fetch;
        // stays here until reset
        st_trap: trap <= 1'b1;
        default: state <= st_trap;
      endcase
    end
  end

  assign rf_we = state == st_writeback;
  assign rf_rd = dec.rd;
  assign rf_wdata = wb_data;

endmodule

//--- logic/rv32i_core.sv
`timescale 1ns/1ps

module rv32i_core
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  output logic     mem_valid,
  output mem_req_t mem_req,
  input  logic     mem_ready,
  input  word_t    mem_rdata,
  output logic     trap
);

  word_t    instr;
  decoded_t dec;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    op_b;
  word_t    alu_result;
  logic     branch_taken;
  mem_req_t data_req;
  logic     misaligned;
  word_t    load_data;
  logic     rf_we;
  reg_idx_t rf_rd;
  word_t    rf_wdata;

  assign op_b = dec.imm_sel ? dec.imm : rs2_data;

  instr_decoder u_decoder (
    .instr (instr),
    .dec   (dec)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (rf_rd),
    .rd_data  (rf_wdata)
  );

  alu u_alu (
    .op_a         (rs1_data),
    .op_b         (op_b),
    .alu_op       (dec.alu_op),
    .funct3       (dec.funct3),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  load_store_unit u_lsu (
    .dec        (dec),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .mem_rdata  (mem_rdata),
    .data_req   (data_req),
    .misaligned (misaligned),
    .load_data  (load_data)
  );

  core_sequencer u_sequencer (
    .clk          (clk),
    .reset        (reset),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata),
    .mem_valid    (mem_valid),
    .mem_req      (mem_req),
    .trap         (trap),
    .instr        (instr),
    .dec          (dec),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .data_req     (data_req),
    .misaligned   (misaligned),
    .load_data    (load_data),
    .rf_we        (rf_we),
    .rf_rd        (rf_rd),
    .rf_wdata     (rf_wdata),
    .rs1_data     (rs1_data)
  );

endmodule

//--- sim/bus_checker.sv
`timescale 1ns/1ps

module bus_checker
  import rv_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     mem_valid,
  input mem_req_t mem_req,
  input logic     mem_ready,
  input logic     trap
);

  word_t      exp_addr [$];
  logic [3:0] exp_strb [$];
  word_t      exp_data [$];
  logic       trap_expected = 1'b0;
  logic       trap_seen = 1'b0;
  int         value_errors = 0;
  int         other_errors = 0;

  function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << b[4:0];
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[4:0];
      alu_sra:  return $signed(a) >>> b[4:0];
      alu_or:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  // lane at the byte offset extended by funct3
  function automatic word_t load_ext(input word_t w, input logic [2:0] f3, input int off);
    word_t s;
    s = w >> (off * 8);
    case (f3)
      3'b000:  return {{24{s[7]}}, s[7:0]};
      3'b100:  return {24'd0, s[7:0]};
      3'b001:  return {{16{s[15]}}, s[15:0]};
      3'b101:  return {16'd0, s[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic clear_expect;
    exp_addr.delete();
    exp_strb.delete();
    exp_data.delete();
    trap_expected = 1'b0;
    trap_seen = 1'b0;
  endtask

  task automatic expect_store(input word_t a, input logic [3:0] s, input word_t d);
    exp_addr.push_back(a);
    exp_strb.push_back(s);
    exp_data.push_back(d);
  endtask

  task automatic expect_trap;
    trap_expected = 1'b1;
  endtask

  function automatic logic is_done;
    return exp_addr.size() == 0 && (!trap_expected || trap_seen);
  endfunction

  always @(posedge clk) begin
    word_t mask;
    logic  fetch_exp;
    if (!reset) begin
      if (mem_valid && mem_ready) begin
        // the program sits below the result area at 0x2000
        fetch_exp = mem_req.addr < 32'h2000;
        if (mem_req.instr !== fetch_exp) begin
          value_errors++;
          $display("CHECK FAILED mem_req.instr expected %h got %h", fetch_exp, mem_req.instr);
        end
      end
      if (mem_valid && mem_ready && mem_req.strb != '0) begin
        if (exp_addr.size() == 0) begin
          other_errors++;
          $display("unexpected write to address %h", mem_req.addr);
        end else begin
          mask = {{8{exp_strb[0][3]}}, {8{exp_strb[0][2]}},
                  {8{exp_strb[0][1]}}, {8{exp_strb[0][0]}}};
          if (mem_req.addr !== exp_addr[0]) begin
            value_errors++;
            $display("CHECK FAILED mem_req.addr expected %h got %h", exp_addr[0], mem_req.addr);
          end
          if (mem_req.strb !== exp_strb[0]) begin
            value_errors++;
            $display("CHECK FAILED mem_req.strb expected %h got %h", exp_strb[0], mem_req.strb);
          end
          if ((mem_req.wdata & mask) !== (exp_data[0] & mask)) begin
            value_errors++;
            $display("CHECK FAILED mem_req.wdata expected %h got %h",
                     exp_data[0] & mask, mem_req.wdata & mask);
          end
          void'(exp_addr.pop_front());
          void'(exp_strb.pop_front());
          void'(exp_data.pop_front());
        end
      end
      if (trap) begin
        if (!trap_expected && !trap_seen) begin
          other_errors++;
          $display("core trapped where no trap was expected");
        end
        trap_seen = 1'b1;
        if (mem_valid) begin
          other_errors++;
          $display("core issued a bus request after trap");
        end
      end
    end
  end

endmodule

//--- sim/tb_top.sv
`timescale 1ns/1ps

module tb_top
  import rv_pkg::*;
();

  logic     clk = 1'b0;
  logic     reset;
  logic     mem_valid;
  mem_req_t mem_req;
  logic     mem_ready;
  word_t    mem_rdata;
  logic     trap;

  word_t  mem [4096];
  integer seed = 32'h420cce23;
  int     pc_idx;
  word_t  res_addr;
  int     limit_cycles;
  int     cycles;
  logic   pending;
  int     wait_cnt;

  always #5 clk = ~clk;

  rv32i_core DUT (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  bus_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .trap      (trap)
  );

  // memory model with a random ready delay of 0 to 3 cycles per handshake
  always @(negedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      pending = 1'b0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;
      pending = 1'b0;
    end else if (mem_valid) begin
      if (!pending) begin
        pending = 1'b1;
        wait_cnt = $random(seed) & 3;
      end
      if (wait_cnt == 0) begin
        for (int i = 0; i < 4; i++) begin
          if (mem_req.strb[i]) begin
            mem[mem_req.addr[13:2]][8*i +: 8] = mem_req.wdata[8*i +: 8];
          end
        end
        mem_rdata <= mem[mem_req.addr[13:2]];
        mem_ready <= 1'b1;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

  // watchdog limit is set per run from the program length
  always @(posedge clk) begin
    if (reset) begin
      cycles = 0;
    end else begin
      cycles = cycles + 1;
      if (cycles > limit_cycles) begin
        $display("timeout: expected store or trap was not seen in %0d cycles", limit_cycles);
        $display("errors: value %0d, other %0d", u_checker.value_errors,
                 u_checker.other_errors + 1);
        $display("TESTBENCH FAILED");
        $finish;
      end
    end
  end

  function automatic word_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                   input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input int rs1, input logic [2:0] f3,
                                   input int rd, input logic [6:0] opc);
    return {imm, rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input int rs2, input int rs1,
                                   input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input int rs2, input int rs1,
                                   input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input int rd, input logic [6:0] opc);
    return {imm, rd[4:0], opc};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  // RISC-V branch rule by funct3
  function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [2:0] funct3_of(input alu_op_e op);
    case (op)
      alu_add, alu_sub: return 3'b000;
      alu_sll:          return 3'b001;
      alu_slt:          return 3'b010;
      alu_sltu:         return 3'b011;
      alu_xor:          return 3'b100;
      alu_srl, alu_sra: return 3'b101;
      alu_or:           return 3'b110;
      default:          return 3'b111;
    endcase
  endfunction

  task automatic emit(input word_t w);
    mem[pc_idx] = w;
    pc_idx++;
  endtask

  task automatic load_const(input int rd, input word_t v);
    word_t upper;
    upper = (v + 32'h800) >> 12;
    emit(u_type(upper[19:0], rd, 7'h37));
    emit(i_type(v[11:0], rd, 3'b000, rd, 7'h13));
  endtask

  // sw rs, 0(x31) then bump the result pointer
  task automatic store_result(input int rs, input word_t expected);
    emit(s_type(12'd0, rs, 31, 3'b010));
    u_checker.expect_store(res_addr, 4'hf, expected);
    emit(i_type(12'd4, 31, 3'b000, 31, 7'h13));
    res_addr += 4;
  endtask

  task automatic store_partial(input logic [2:0] f3, input int off, input word_t v);
    logic [3:0] strb;
    word_t      data;
    if (f3 == 3'b000) begin
      strb = 4'b0001 << off;
      data = {4{v[7:0]}};
    end else begin
      strb = (off == 2) ? 4'b1100 : 4'b0011;
      data = {2{v[15:0]}};
    end
    emit(s_type(off[11:0], 5, 31, f3));
    u_checker.expect_store(res_addr, strb, data);
    emit(i_type(12'd4, 31, 3'b000, 31, 7'h13));
    res_addr += 4;
  endtask

  task automatic start_run;
    @(negedge clk);
    reset = 1'b1;
    limit_cycles = 1000000;
    u_checker.clear_expect();
    // unused words hold their index above an illegal opcode
    for (int i = 0; i < 4096; i++) begin
      mem[i] = {i[19:0], 12'h07f};
    end
    pc_idx = 0;
    res_addr = 32'h2000;
  endtask

  task automatic finish_run(input logic trap_case);
    limit_cycles = (pc_idx + 10) * 40;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    while (!u_checker.is_done()) @(negedge clk);
    // no request may follow a trap
    if (trap_case) repeat (20) @(negedge clk);
  endtask

  task automatic alu_tests;
    alu_op_e    op;
    word_t      a;
    word_t      b;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    for (int n = 0; n < 20; n++) begin
      op = alu_op_e'($unsigned($random(seed)) % 10);
      a = $random(seed);
      b = $random(seed);
      f3 = funct3_of(op);
      f7 = (op == alu_sub || op == alu_sra) ? 7'h20 : 7'h00;
      load_const(1, a);
      if (op != alu_sub && ($random(seed) & 1)) begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          b = b & 31;
          imm = {f7, b[4:0]};
        end else begin
          imm = b[11:0];
          b = {{20{imm[11]}}, imm};
        end
        emit(i_type(imm, 1, f3, 3, 7'h13));
      end else begin
        load_const(2, b);
        emit(r_type(f7, 2, 1, f3, 3));
      end
      store_result(3, u_checker.ref_alu(op, a, b));
    end
  endtask

  task automatic load_store_tests;
    word_t      data_word;
    word_t      v;
    logic [2:0] sizes [5];
    int         step;
    data_word = $random(seed);
    mem[32'h3000 >> 2] = data_word;
    sizes = '{3'b000, 3'b100, 3'b001, 3'b101, 3'b010};
    for (int s = 0; s < 5; s++) begin
      step = 1 << sizes[s][1:0];
      for (int off = 0; off < 4; off += step) begin
        emit(i_type(off[11:0], 11, sizes[s], 5, 7'h03));
        store_result(5, u_checker.load_ext(data_word, sizes[s], off));
      end
    end
    v = $random(seed);
    load_const(5, v);
    for (int off = 0; off < 4; off++) store_partial(3'b000, off, v);
    for (int off = 0; off < 4; off += 2) store_partial(3'b001, off, v);
  endtask

  task automatic branch_tests;
    logic [2:0] conds [6];
    word_t      a;
    word_t      b;
    word_t      pc;
    logic       taken;
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    for (int c = 0; c < 6; c++) begin
      for (int want = 0; want < 2; want++) begin
        a = $random(seed);
        b = $random(seed);
        while (branch_ref(conds[c], a, b) != want[0]) begin
          b = ($random(seed) & 1) ? a : $random(seed);
        end
        taken = want[0];
        load_const(1, a);
        load_const(2, b);
        emit(i_type(12'd0, 0, 3'b000, 5, 7'h13));
        // taken skips the marker write
        emit(b_type(13'd8, 2, 1, conds[c]));
        emit(i_type(12'd1, 0, 3'b000, 5, 7'h13));
        store_result(5, taken ? 32'd0 : 32'd1);
      end
    end
    // the skipped word clears the link register
    pc = pc_idx * 4;
    emit(j_type(21'd8, 6));
    emit(i_type(12'd0, 0, 3'b000, 6, 7'h13));
    store_result(6, pc + 4);
    pc = pc_idx * 4;
    emit(u_type(20'd0, 7, 7'h17));
    emit(i_type(12'd12, 7, 3'b000, 6, 7'h67));
    emit(i_type(12'd0, 0, 3'b000, 6, 7'h13));
    store_result(6, pc + 8);
  endtask

  initial begin
    int total;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    limit_cycles = 1000000;

    start_run();
    emit(u_type(20'd2, 31, 7'h37));
    emit(u_type(20'd3, 11, 7'h37));
    alu_tests();
    load_store_tests();
    branch_tests();
    emit(j_type(21'd0, 0));
    finish_run(1'b0);

    // misaligned lw
    start_run();
    emit(u_type(20'd3, 11, 7'h37));
    emit(i_type(12'd1, 11, 3'b010, 5, 7'h03));
    // spins if the fault is missed
    emit(j_type(21'd0, 0));
    u_checker.expect_trap();
    finish_run(1'b1);

    // misaligned sh
    start_run();
    emit(u_type(20'd3, 11, 7'h37));
    emit(s_type(12'd1, 5, 11, 3'b001));
    u_checker.expect_trap();
    finish_run(1'b1);

    start_run();
    emit(32'h0000007f);
    emit(j_type(21'd0, 0));
    u_checker.expect_trap();
    finish_run(1'b1);

    // jalr target 0x102
    start_run();
    emit(i_type(12'h102, 0, 3'b000, 7, 7'h13));
    emit(i_type(12'd0, 7, 3'b000, 0, 7'h67));
    mem[32'h100 >> 2] = j_type(21'd0, 0);
    u_checker.expect_trap();
    finish_run(1'b1);

    total = u_checker.value_errors + u_checker.other_errors;
    $display("errors: value %0d, other %0d", u_checker.value_errors, u_checker.other_errors);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
logic/rv_pkg.sv
logic/instr_decoder.sv
logic/alu.sv
logic/load_store_unit.sv
logic/reg_file.sv
logic/core_sequencer.sv
logic/rv32i_core.sv
sim/bus_checker.sv
sim/tb_top.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_top -f sim.f
	verilator --lint-only --top-module rv32i_core logic/rv_pkg.sv logic/instr_decoder.sv \
		logic/alu.sv logic/load_store_unit.sv logic/reg_file.sv \
		logic/core_sequencer.sv logic/rv32i_core.sv

sim:
	verilator --binary --timing --top-module tb_top -f sim.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
